//--- filelist.f
rtl/fpu_rnd_pkg.sv
rtl/fpu_rnd_src_mux.sv
rtl/fpu_rnd_align.sv
rtl/fpu_rnd_round.sv
rtl/fpu_rnd_pack.sv
rtl/fpu_rnd_wb_hold.sv
rtl/fpu_rnd_top.sv
bench/fpu_rnd_asserts.sv
bench/tb_fpu_rnd.sv

//--- Bender.yml
package:
  name: fpu_rnd

sources:
  - rtl/fpu_rnd_pkg.sv
  - rtl/fpu_rnd_src_mux.sv
  - rtl/fpu_rnd_align.sv
  - rtl/fpu_rnd_round.sv
  - rtl/fpu_rnd_pack.sv
  - rtl/fpu_rnd_wb_hold.sv
  - rtl/fpu_rnd_top.sv
  - target: simulation
    files:
      - bench/fpu_rnd_asserts.sv
      - bench/tb_fpu_rnd.sv

//--- bench/tb_fpu_rnd.sv
/*
  testbench for the rounding pipeline
  random adder and multiplier results against a reference model,
  random write-back back-pressure and a flush mid-stream
*/

module tb_fpu_rnd
  import fpu_rnd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned N_ITEMS  = 48;
  localparam int unsigned N_BATCH  = 8;
  localparam int unsigned MAX_WAIT = 4000;

  logic      cpu_clk;
  logic      rst_n_i;
  logic      pipeline_flush_i;
  logic      add_rdy_i;
  logic      add_sign_i;
  logic      add_sub_zero_i;
  exp10_t    add_exp_i;
  shift5_t   add_shl_i;
  fract28_t  add_fract_i;
  logic      mul_rdy_i;
  logic      mul_sign_i;
  exp10_t    mul_exp_i;
  shift5_t   mul_shr_i;
  fract28_t  mul_fract_i;
  rnd_mode_t rm_i;
  logic      inv_i;
  logic      inf_i;
  logic      snan_i;
  logic      qnan_i;
  logic      anan_sign_i;
  flags_t    fpu_mask_flags_i;
  logic      taking_add_o;
  logic      taking_mul_o;
  logic      res_valid_o;
  fp32_t     res_o;
  flags_t    flags_o;
  logic      wb_take_i;

  logic [31:0] lfsr_q;
  fp32_t       exp_res_q[$];
  flags_t      exp_flags_q[$];
  logic        stall_seen;

  fpu_rnd_top u_dut (.*);

  initial begin
    cpu_clk = 1'b0;
    forever #10 cpu_clk = ~cpu_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // random source, galois lfsr, one step per bit
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_v);
    if (got !== exp_v) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp_v);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_msg(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model, built from the rounding and packing rules
  //////////////////////////////////////////////////////////////////////

  task automatic model_push();
    logic        is_add;
    logic        sgn;
    logic        rsh;
    int          sh;
    exp10_t      e;
    fract28_t    f;
    fract28_t    fs;
    logic        sticky;
    logic        rb;
    logic        lost;
    logic        up;
    logic [24:0] mant;
    logic [23:0] frac;
    fp32_t       r;
    flags_t      fl;
    is_add = add_rdy_i;
    sgn = is_add ? (add_sub_zero_i ? (rm_i == RM_TO_INFM) : add_sign_i) : mul_sign_i;
    e = is_add ? add_exp_i : mul_exp_i;
    f = is_add ? add_fract_i : mul_fract_i;
    // right shift from multiplier, carry, else adder left shift
    if (!is_add && mul_shr_i != 0) begin
      rsh = 1'b1;
      sh = mul_shr_i;
    end else if (f[27]) begin
      rsh = 1'b1;
      sh = 1;
    end else begin
      rsh = 1'b0;
      sh = is_add ? add_shl_i : 0;
    end
    e = rsh ? e + exp10_t'(sh) : e - exp10_t'(sh);
    sticky = 1'b0;
    if (rsh) begin
      fs = f >> sh;
      for (int i = 0; i < sh && i < 28; i++) sticky = sticky | f[i];
    end else begin
      fs = f << sh;
    end
    sticky = sticky | fs[1] | fs[0];
    rb = fs[2];
    lost = rb | sticky;
    case (rm_i)
      RM_NEAREST: up = rb & (sticky | fs[3]);
      RM_TO_INFP: up = ~sgn & lost;
      RM_TO_INFM: up = sgn & lost;
      default:    up = 1'b0;
    endcase
    mant = fs[27:3] + 25'(up);
    if (mant[24]) begin
      frac = mant[24:1];
      e = e + 10'd1;
    end else begin
      frac = mant[23:0];
    end
    fl = '0;
    fl[FLAG_SNAN] = snan_i;
    fl[FLAG_QNAN] = qnan_i;
    fl[FLAG_INV]  = inv_i | snan_i;
    if (qnan_i | snan_i) begin
      r = {anan_sign_i, 31'h7fc0_0000};
    end else if (inv_i) begin
      r = {sgn, 31'h7fbf_ffff};
    end else if ($signed(e) > 254 || inf_i) begin
      r = {sgn, 31'h7f80_0000};
      fl[FLAG_INF] = 1'b1;
      fl[FLAG_OVF] = ~inf_i;
      fl[FLAG_INE] = lost | ~inf_i;
    end else if (!frac[23]) begin
      r = {sgn, 8'd0, frac[22:0]};
      fl[FLAG_UNF]  = lost;
      fl[FLAG_INE]  = lost;
      fl[FLAG_ZERO] = (frac == 24'd0);
    end else begin
      r = {sgn, e[7:0], frac[22:0]};
      fl[FLAG_INE] = lost;
    end
    exp_res_q.push_back(r);
    exp_flags_q.push_back(fl & fpu_mask_flags_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus item
  //////////////////////////////////////////////////////////////////////

  task automatic drive_item();
    logic       use_mul;
    logic [2:0] cat;
    exp10_t     e;
    fract28_t   f;
    shift5_t    sh;
    logic [1:0] which;
    use_mul = rnd(1);
    cat = rnd(3);
    e = 10'd64 + exp10_t'(rnd(7));
    // carry set now and then
    f = {(rnd(3) == 0), 1'b1, 26'(rnd(26))};
    sh = 5'(rnd(2));
    if (!use_mul && !f[27]) f = f >> sh;
    which = rnd(2);
    // tie on the round bit
    if (cat == 3'd1) f[2:0] = 3'b100;
    // overflow region
    if (cat == 3'd4) e = 10'd250 + exp10_t'(rnd(3));
    // tiny exponent, wide multiplier shift gives denormals
    if (cat == 3'd5) begin
      e = exp10_t'(rnd(2));
      sh = use_mul ? 5'(rnd(5)) : 5'd0;
    end
    // all ones below the carry, rounding up carries into bit 24
    if (cat == 3'd6) begin
      f = {2'b01, 26'h3ff_ffff};
      sh = 5'd0;
    end
    add_rdy_i      <= ~use_mul;
    mul_rdy_i      <= use_mul;
    add_sign_i     <= rnd(1);
    mul_sign_i     <= rnd(1);
    add_sub_zero_i <= (cat == 3'd2) && !use_mul;
    add_exp_i      <= e;
    mul_exp_i      <= e;
    add_shl_i      <= (cat == 3'd2) ? 5'd0 : sh;
    mul_shr_i      <= sh;
    add_fract_i    <= (cat == 3'd2 && !use_mul) ? 28'd0 : f;
    mul_fract_i    <= f;
    inv_i          <= (cat == 3'd3) && (which == 2'd0);
    inf_i          <= (cat == 3'd3) && (which == 2'd1);
    snan_i         <= (cat == 3'd3) && (which == 2'd2);
    qnan_i         <= (cat == 3'd3) && (which == 2'd3);
    anan_sign_i    <= rnd(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned sent;
    int unsigned cycles;
    logic        pending;
    logic        xfer;
    logic        bp;
    logic        flushed;
    lfsr_q = 32'hf411_2890;
    stall_seen = 1'b0;
    rst_n_i = 1'b0;
    pipeline_flush_i = 1'b0;
    add_rdy_i = 1'b0;
    add_sign_i = 1'b0;
    add_sub_zero_i = 1'b0;
    add_exp_i = '0;
    add_shl_i = '0;
    add_fract_i = '0;
    mul_rdy_i = 1'b0;
    mul_sign_i = 1'b0;
    mul_exp_i = '0;
    mul_shr_i = '0;
    mul_fract_i = '0;
    rm_i = RM_NEAREST;
    inv_i = 1'b0;
    inf_i = 1'b0;
    snan_i = 1'b0;
    qnan_i = 1'b0;
    anan_sign_i = 1'b0;
    fpu_mask_flags_i = 8'hff;
    wb_take_i = 1'b0;
    repeat (5) @(posedge cpu_clk);
    rst_n_i <= 1'b1;
    for (int b = 0; b < N_BATCH; b++) begin
      @(posedge cpu_clk);
      // mode and mask only change with the pipeline empty
      rm_i <= rnd_mode_t'(b % 4);
      fpu_mask_flags_i <= (b < 4) ? 8'hff : flags_t'(rnd(8));
      bp = (b >= 4);
      sent = 0;
      cycles = 0;
      pending = 1'b0;
      flushed = 1'b0;
      while (sent < N_ITEMS || pending || exp_res_q.size() != 0) begin
        @(negedge cpu_clk);
        cycles++;
        if (cycles > MAX_WAIT) begin
          fail_msg("Timeout: results did not drain from the pipeline");
        end
        xfer = (add_rdy_i & taking_add_o) | (mul_rdy_i & taking_mul_o);
        if ((add_rdy_i | mul_rdy_i) && !xfer) stall_seen = 1'b1;
        if (xfer) begin
          model_push();
          sent++;
          pending = 1'b0;
        end
        if (res_valid_o && wb_take_i) begin
          if (exp_res_q.size() == 0) begin
            fail_msg("Result offered with no item outstanding");
          end
          check_value("res_o", res_o, exp_res_q.pop_front());
          check_value("flags_o", {24'd0, flags_o}, {24'd0, exp_flags_q.pop_front()});
        end
        @(posedge cpu_clk);
        if (b == 6 && sent == 20 && !flushed) begin
          // drop everything in flight
          flushed = 1'b1;
          pending = 1'b0;
          pipeline_flush_i <= 1'b1;
          add_rdy_i <= 1'b0;
          mul_rdy_i <= 1'b0;
          wb_take_i <= 1'b0;
          @(posedge cpu_clk);
          pipeline_flush_i <= 1'b0;
          exp_res_q.delete();
          exp_flags_q.delete();
          @(negedge cpu_clk);
          check_value("res_valid_o", {31'd0, res_valid_o}, 32'd0);
        end else begin
          if (!pending && sent < N_ITEMS && (bp || rnd(2) != 0)) begin
            drive_item();
            pending = 1'b1;
          end else if (!pending) begin
            add_rdy_i <= 1'b0;
            mul_rdy_i <= 1'b0;
          end
          wb_take_i <= bp ? rnd(1) : 1'b1;
        end
      end
    end
    if (!stall_seen) begin
      $display("Back-pressure never stalled the input handshake");
      $display("Test FAILED");
      $fatal(1);
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- bench/fpu_rnd_asserts.sv
/*
  handshake assertions for the rounding pipeline
  bound to the top level
*/

module fpu_rnd_asserts
  import fpu_rnd_pkg::*;
(
  input logic  cpu_clk,
  input logic  rst_n_i,
  input logic  pipeline_flush_i,
  input logic  add_rdy_i,
  input logic  mul_rdy_i,
  input logic  res_valid_o,
  input fp32_t res_o,
  input logic  wb_take_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // one source at a time
  one_source_a : assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
    !(add_rdy_i && mul_rdy_i))
    else $error("adder and multiplier ready together");

  // offered result waits for write-back
  res_stable_a : assert property (@(posedge cpu_clk) disable iff (!rst_n_i)
    (res_valid_o && !wb_take_i && !pipeline_flush_i) |=> $stable(res_o))
    else $error("result changed before write-back took it");

  // nothing valid right out of reset
  reset_idle_a : assert property (@(posedge cpu_clk)
    $rose(rst_n_i) |-> !res_valid_o)
    else $error("result valid right after reset");

endmodule

bind fpu_rnd_top fpu_rnd_asserts u_asserts (.*);

//--- rtl/fpu_rnd_top.sv
/*
  single-precision rounding pipeline top level
  src mux, align, round, pack and write-back hold in a chain
*/

module fpu_rnd_top
  import fpu_rnd_pkg::*;
(
  input  logic       cpu_clk,
  input  logic       rst_n_i,
  input  logic       pipeline_flush_i,
  input  logic       add_rdy_i,
  input  logic       add_sign_i,
  input  logic       add_sub_zero_i,
  input  exp10_t     add_exp_i,
  input  shift5_t    add_shl_i,
  input  fract28_t   add_fract_i,
  input  logic       mul_rdy_i,
  input  logic       mul_sign_i,
  input  exp10_t     mul_exp_i,
  input  shift5_t    mul_shr_i,
  input  fract28_t   mul_fract_i,
  input  rnd_mode_t  rm_i,
  input  logic       inv_i,
  input  logic       inf_i,
  input  logic       snan_i,
  input  logic       qnan_i,
  input  logic       anan_sign_i,
  input  flags_t     fpu_mask_flags_i,
  output logic       taking_add_o,
  output logic       taking_mul_o,
  output logic       res_valid_o,
  output fp32_t      res_o,
  output flags_t     flags_o,
  input  logic       wb_take_i
);

  // stage 0
  logic        s0_ready;
  logic        s0_sign;
  logic        s0_is_shr;
  shift5_t     s0_shift;
  exp10_t      s0_exp;
  fract28_t    s0_fract;
  logic [4:0]  s0_spec;
  // stage 1
  logic        s1_ready;
  logic        s1_busy;
  logic        s1_sign;
  exp10_t      s1_exp;
  fract26_t    s1_fract;
  logic        s1_sticky;
  logic [4:0]  s1_spec;
  // stage 2
  logic        s2_ready;
  logic        s2_busy;
  logic        s2_sign;
  exp10_t      s2_exp;
  logic [24:0] s2_mant;
  logic        s2_lost;
  logic [4:0]  s2_spec;
  // pack and hold
  fp32_t       exec_res;
  flags_t      exec_flags;
  logic        hold_busy;

  // stage 2 load strobe, seen by the hold stage
  wire s2_adv = s1_ready & ~s2_busy;

  fpu_rnd_src_mux u_src_mux (
    .cpu_clk        (cpu_clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (pipeline_flush_i),
    .add_rdy_i      (add_rdy_i),
    .add_sign_i     (add_sign_i),
    .add_sub_zero_i (add_sub_zero_i),
    .add_exp_i      (add_exp_i),
    .add_shl_i      (add_shl_i),
    .add_fract_i    (add_fract_i),
    .mul_rdy_i      (mul_rdy_i),
    .mul_sign_i     (mul_sign_i),
    .mul_exp_i      (mul_exp_i),
    .mul_shr_i      (mul_shr_i),
    .mul_fract_i    (mul_fract_i),
    .rm_i           (rm_i),
    .inv_i          (inv_i),
    .inf_i          (inf_i),
    .snan_i         (snan_i),
    .qnan_i         (qnan_i),
    .anan_sign_i    (anan_sign_i),
    .s1_busy_i      (s1_busy),
    .taking_add_o   (taking_add_o),
    .taking_mul_o   (taking_mul_o),
    .s0_ready_o     (s0_ready),
    .s0_busy_o      (),
    .s0_sign_o      (s0_sign),
    .s0_is_shr_o    (s0_is_shr),
    .s0_shift_o     (s0_shift),
    .s0_exp_o       (s0_exp),
    .s0_fract_o     (s0_fract),
    .s0_spec_o      (s0_spec)
  );

  fpu_rnd_align u_align (
    .cpu_clk     (cpu_clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (pipeline_flush_i),
    .s0_ready_i  (s0_ready),
    .s0_sign_i   (s0_sign),
    .s0_is_shr_i (s0_is_shr),
    .s0_shift_i  (s0_shift),
    .s0_exp_i    (s0_exp),
    .s0_fract_i  (s0_fract),
    .s0_spec_i   (s0_spec),
    .s2_busy_i   (s2_busy),
    .s1_ready_o  (s1_ready),
    .s1_busy_o   (s1_busy),
    .s1_sign_o   (s1_sign),
    .s1_exp_o    (s1_exp),
    .s1_fract_o  (s1_fract),
    .s1_sticky_o (s1_sticky),
    .s1_spec_o   (s1_spec)
  );

  fpu_rnd_round u_round (
    .cpu_clk     (cpu_clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (pipeline_flush_i),
    .s1_ready_i  (s1_ready),
    .s1_sign_i   (s1_sign),
    .s1_exp_i    (s1_exp),
    .s1_fract_i  (s1_fract),
    .s1_sticky_i (s1_sticky),
    .s1_spec_i   (s1_spec),
    .rm_i        (rm_i),
    .hold_busy_i (hold_busy),
    .s2_ready_o  (s2_ready),
    .s2_busy_o   (s2_busy),
    .s2_sign_o   (s2_sign),
    .s2_exp_o    (s2_exp),
    .s2_mant_o   (s2_mant),
    .s2_lost_o   (s2_lost),
    .s2_spec_o   (s2_spec)
  );

  // combinational on the stage 2 registers
  fpu_rnd_pack u_pack (
    .s2_sign_i (s2_sign),
    .s2_exp_i  (s2_exp),
    .s2_mant_i (s2_mant),
    .s2_lost_i (s2_lost),
    .s2_spec_i (s2_spec),
    .mask_i    (fpu_mask_flags_i),
    .res_o     (exec_res),
    .flags_o   (exec_flags)
  );

  fpu_rnd_wb_hold u_wb_hold (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (pipeline_flush_i),
    .s2_ready_i   (s2_ready),
    .s2_adv_i     (s2_adv),
    .exec_res_i   (exec_res),
    .exec_flags_i (exec_flags),
    .wb_take_i    (wb_take_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .flags_o      (flags_o),
    .hold_busy_o  (hold_busy)
  );

endmodule

//--- rtl/fpu_rnd_wb_hold.sv
/*
  write-back hold stage
  keeps result valid, tracks a missed write-back and
  holds the packed result and flags until taken
*/

module fpu_rnd_wb_hold
  import fpu_rnd_pkg::*;
(
  input  logic    cpu_clk,
  input  logic    rst_n_i,
  input  logic    flush_i,
  input  logic    s2_ready_i,
  input  logic    s2_adv_i,
  input  fp32_t   exec_res_i,
  input  flags_t  exec_flags_i,
  input  logic    wb_take_i,
  output logic    res_valid_o,
  output fp32_t   res_o,
  output flags_t  flags_o,
  output logic    hold_busy_o
);

  logic    wb_miss;
  logic    take;
  fp32_t   held_res;
  flags_t  held_flags;

  assign take        = wb_take_i & res_valid_o;
  assign hold_busy_o = wb_miss;

  // offered but not taken
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_miss <= 1'b0;
    end else if (flush_i) begin
      wb_miss <= 1'b0;
    end else if (take) begin
      wb_miss <= 1'b0;
    end else if (!wb_miss) begin
      wb_miss <= s2_ready_i;
    end
  end

  // freeze a copy once missed
  always_ff @(posedge cpu_clk) begin
    if (!wb_miss) begin
      held_res   <= exec_res_i;
      held_flags <= exec_flags_i;
    end
  end

  // stays up after a take if stage 2 still has the next item
  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_o <= 1'b0;
    end else if (flush_i) begin
      res_valid_o <= 1'b0;
    end else if (s2_adv_i) begin
      res_valid_o <= 1'b1;
    end else if (take) begin
      res_valid_o <= wb_miss ? s2_ready_i : 1'b0;
    end
  end

  assign res_o   = wb_miss ? held_res : exec_res_i;
  assign flags_o = wb_miss ? held_flags : exec_flags_i;

endmodule

//--- rtl/fpu_rnd_pack.sv
/*
  final renormalisation and binary32 packing
  picks special results by priority and builds the masked flags
*/

module fpu_rnd_pack
  import fpu_rnd_pkg::*;
(
  input  logic        s2_sign_i,
  input  exp10_t      s2_exp_i,
  input  logic [24:0] s2_mant_i,
  input  logic        s2_lost_i,
  input  logic [4:0]  s2_spec_i,
  input  flags_t      mask_i,
  output fp32_t       res_o,
  output flags_t      flags_o
);

  logic        spec_inv;
  logic        spec_inf;
  logic        spec_snan;
  logic        spec_qnan;
  logic        anan_sign;
  logic        norm_shr;
  exp10_t      exp_fin;
  logic [23:0] fract_fin;
  logic        is_dn;
  logic        is_ovf;
  fp32_t       res_w;
  flags_t      flags_w;

  assign {spec_inv, spec_inf, spec_snan, spec_qnan, anan_sign} = s2_spec_i;

  //////////////////////////////////////////////////////////////////////
  // renormalise after rounding carry
  //////////////////////////////////////////////////////////////////////

  assign norm_shr  = s2_mant_i[24];
  assign exp_fin   = s2_exp_i + {9'd0, norm_shr};
  assign fract_fin = norm_shr ? s2_mant_i[24:1] : s2_mant_i[23:0];

  // hidden bit clear means denormal or zero
  assign is_dn  = ~fract_fin[23];
  assign is_ovf = ($signed(exp_fin) > $signed(EXP_MAX)) | spec_inf;

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    flags_w = '0;
    // order buffer flags pass regardless of class
    flags_w[FLAG_SNAN] = spec_snan;
    flags_w[FLAG_QNAN] = spec_qnan;
    flags_w[FLAG_INV]  = spec_inv | spec_snan;
    if (spec_qnan | spec_snan) begin
      res_w = {anan_sign, QNAN_S};
    end else if (spec_inv) begin
      res_w = {s2_sign_i, SNAN_S};
    end else if (is_ovf) begin
      res_w = {s2_sign_i, INF_S};
      flags_w[FLAG_INF] = 1'b1;
      // a true infinity operand is exact
      flags_w[FLAG_OVF] = ~spec_inf;
      flags_w[FLAG_INE] = s2_lost_i | ~spec_inf;
    end else if (is_dn) begin
      res_w = {s2_sign_i, 8'd0, fract_fin[22:0]};
      flags_w[FLAG_UNF]  = s2_lost_i;
      flags_w[FLAG_INE]  = s2_lost_i;
      flags_w[FLAG_ZERO] = ~(|fract_fin);
    end else begin
      res_w = {s2_sign_i, exp_fin[7:0], fract_fin[22:0]};
      flags_w[FLAG_INE] = s2_lost_i;
    end
  end

  assign res_o   = res_w;
  assign flags_o = flags_w & mask_i;

endmodule

//--- rtl/fpu_rnd_round.sv
/*
  rounding pipeline stage 2
  decides the rounding increment for the active mode
  and adds it to the 25-bit mantissa
*/

module fpu_rnd_round
  import fpu_rnd_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        rst_n_i,
  input  logic        flush_i,
  input  logic        s1_ready_i,
  input  logic        s1_sign_i,
  input  exp10_t      s1_exp_i,
  input  fract26_t    s1_fract_i,
  input  logic        s1_sticky_i,
  input  logic [4:0]  s1_spec_i,
  input  rnd_mode_t   rm_i,
  input  logic        hold_busy_i,
  output logic        s2_ready_o,
  output logic        s2_busy_o,
  output logic        s2_sign_o,
  output exp10_t      s2_exp_o,
  output logic [24:0] s2_mant_o,
  output logic        s2_lost_o,
  output logic [4:0]  s2_spec_o
);

  logic        s2_adv;
  logic        rnd_bit;
  logic        lsb;
  logic        lost;
  logic        rnd_up;
  logic [24:0] mant_rnd;

  assign s2_busy_o = s2_ready_o & hold_busy_i;
  assign s2_adv    = s1_ready_i & ~s2_busy_o;

  assign rnd_bit = s1_fract_i[0];
  assign lsb     = s1_fract_i[1];
  assign lost    = rnd_bit | s1_sticky_i;

  always_comb begin
    case (rm_i)
      // ties go to even
      RM_NEAREST: rnd_up = rnd_bit & (s1_sticky_i | lsb);
      RM_TO_INFP: rnd_up = ~s1_sign_i & lost;
      RM_TO_INFM: rnd_up = s1_sign_i & lost;
      default:    rnd_up = 1'b0;
    endcase
  end

  // may carry into bit 24, fixed up in pack
  assign mant_rnd = s1_fract_i[25:1] + {24'd0, rnd_up};

  always_ff @(posedge cpu_clk) begin
    if (s2_adv) begin
      s2_sign_o <= s1_sign_i;
      s2_exp_o  <= s1_exp_i;
      s2_mant_o <= mant_rnd;
      s2_lost_o <= lost;
      s2_spec_o <= s1_spec_i;
    end
  end

  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s2_ready_o <= 1'b0;
    end else if (flush_i) begin
      s2_ready_o <= 1'b0;
    end else if (s2_adv) begin
      s2_ready_o <= 1'b1;
    end else if (!hold_busy_i) begin
      s2_ready_o <= 1'b0;
    end
  end

endmodule

//--- rtl/fpu_rnd_align.sv
/*
  rounding pipeline stage 1
  shifts the fraction by the effective shift, folds the
  bits below the round position into a sticky bit
*/

module fpu_rnd_align
  import fpu_rnd_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        rst_n_i,
  input  logic        flush_i,
  input  logic        s0_ready_i,
  input  logic        s0_sign_i,
  input  logic        s0_is_shr_i,
  input  shift5_t     s0_shift_i,
  input  exp10_t      s0_exp_i,
  input  fract28_t    s0_fract_i,
  input  logic [4:0]  s0_spec_i,
  input  logic        s2_busy_i,
  output logic        s1_ready_o,
  output logic        s1_busy_o,
  output logic        s1_sign_o,
  output exp10_t      s1_exp_o,
  output fract26_t    s1_fract_o,
  output logic        s1_sticky_o,
  output logic [4:0]  s1_spec_o
);

  logic        s1_adv;
  logic [55:0] ext_in;
  logic [55:0] ext_sh;

  assign s1_busy_o = s1_ready_o & s2_busy_i;
  assign s1_adv    = s0_ready_i & ~s1_busy_o;

  // fraction on top, room below to catch shifted-out bits
  assign ext_in = {s0_fract_i, 28'd0};
  assign ext_sh = s0_is_shr_i ? (ext_in >> s0_shift_i) : (ext_in << s0_shift_i);

  always_ff @(posedge cpu_clk) begin
    if (s1_adv) begin
      s1_sign_o   <= s0_sign_i;
      s1_exp_o    <= s0_exp_i;
      // bits 27..2 of the shifted fraction
      s1_fract_o  <= ext_sh[55:30];
      // low guard pair plus everything shifted out
      s1_sticky_o <= |ext_sh[29:0];
      s1_spec_o   <= s0_spec_i;
    end
  end

  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_ready_o <= 1'b0;
    end else if (flush_i) begin
      s1_ready_o <= 1'b0;
    end else if (s1_adv) begin
      s1_ready_o <= 1'b1;
    end else if (!s2_busy_i) begin
      s1_ready_o <= 1'b0;
    end
  end

endmodule

//--- rtl/fpu_rnd_src_mux.sv
/*
  rounding pipeline stage 0
  picks adder or multiplier result, derives the effective shift
  and the adjusted exponent, registers them with the special flags
*/

module fpu_rnd_src_mux
  import fpu_rnd_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        rst_n_i,
  input  logic        flush_i,
  // adder side
  input  logic        add_rdy_i,
  input  logic        add_sign_i,
  input  logic        add_sub_zero_i,
  input  exp10_t      add_exp_i,
  input  shift5_t     add_shl_i,
  input  fract28_t    add_fract_i,
  // multiplier side
  input  logic        mul_rdy_i,
  input  logic        mul_sign_i,
  input  exp10_t      mul_exp_i,
  input  shift5_t     mul_shr_i,
  input  fract28_t    mul_fract_i,
  input  rnd_mode_t   rm_i,
  // order buffer flags
  input  logic        inv_i,
  input  logic        inf_i,
  input  logic        snan_i,
  input  logic        qnan_i,
  input  logic        anan_sign_i,
  input  logic        s1_busy_i,
  output logic        taking_add_o,
  output logic        taking_mul_o,
  output logic        s0_ready_o,
  output logic        s0_busy_o,
  output logic        s0_sign_o,
  output logic        s0_is_shr_o,
  output shift5_t     s0_shift_o,
  output exp10_t      s0_exp_o,
  output fract28_t    s0_fract_o,
  output logic [4:0]  s0_spec_o
);

  logic      s0_adv;
  logic      add_sign_eff;
  logic      sel_sign;
  exp10_t    sel_exp;
  fract28_t  sel_fract;
  logic      mul_shr_nz;
  logic      nxt_is_shr;
  shift5_t   nxt_shift;
  exp10_t    nxt_exp;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  assign s0_busy_o    = s0_ready_o & s1_busy_i;
  assign s0_adv       = (add_rdy_i | mul_rdy_i) & ~s0_busy_o;
  assign taking_add_o = add_rdy_i & ~s0_busy_o;
  assign taking_mul_o = mul_rdy_i & ~s0_busy_o;

  //////////////////////////////////////////////////////////////////////
  // source select and shift
  //////////////////////////////////////////////////////////////////////

  // exact zero difference, negative only toward minus infinity
  assign add_sign_eff = add_sub_zero_i ? (rm_i == RM_TO_INFM) : add_sign_i;
  assign sel_sign     = add_rdy_i ? add_sign_eff : mul_sign_i;
  assign sel_exp      = add_rdy_i ? add_exp_i : mul_exp_i;
  assign sel_fract    = add_rdy_i ? add_fract_i : mul_fract_i;
  assign mul_shr_nz   = mul_rdy_i & (|mul_shr_i);

  // multiplier shift wins, then carry, then adder left shift
  always_comb begin
    if (mul_shr_nz) begin
      nxt_is_shr = 1'b1;
      nxt_shift  = mul_shr_i;
    end else if (sel_fract[27]) begin
      nxt_is_shr = 1'b1;
      nxt_shift  = 5'd1;
    end else begin
      nxt_is_shr = 1'b0;
      nxt_shift  = add_rdy_i ? add_shl_i : 5'd0;
    end
  end

  assign nxt_exp = nxt_is_shr ? (sel_exp + {5'd0, nxt_shift}) :
                                (sel_exp - {5'd0, nxt_shift});

  // payload
  always_ff @(posedge cpu_clk) begin
    if (s0_adv) begin
      s0_sign_o   <= sel_sign;
      s0_is_shr_o <= nxt_is_shr;
      s0_shift_o  <= nxt_shift;
      s0_exp_o    <= nxt_exp;
      s0_fract_o  <= sel_fract;
      // inv, inf, snan, qnan, nan sign
      s0_spec_o   <= {inv_i, inf_i, snan_i, qnan_i, anan_sign_i};
    end
  end

  always_ff @(posedge cpu_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s0_ready_o <= 1'b0;
    end else if (flush_i) begin
      s0_ready_o <= 1'b0;
    end else if (s0_adv) begin
      s0_ready_o <= 1'b1;
    end else if (!s1_busy_i) begin
      // item moved on to stage 1
      s0_ready_o <= 1'b0;
    end
  end

endmodule

//--- rtl/fpu_rnd_pkg.sv
/*
  fpu rounding pipeline shared definitions
  widths, rounding modes, flag positions and binary32 constants
*/

package fpu_rnd_pkg;

  // unrounded fraction: carry, hidden, 23 fraction bits, 3 guard bits
  typedef logic [27:0] fract28_t;
  // aligned fraction: carry, hidden, 23 fraction bits, round bit
  typedef logic [25:0] fract26_t;
  // biased exponent, two's complement with headroom
  typedef logic [9:0]  exp10_t;
  typedef logic [4:0]  shift5_t;
  typedef logic [7:0]  flags_t;
  typedef logic [31:0] fp32_t;

  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,
    RM_TO_ZERO = 2'd1,
    RM_TO_INFP = 2'd2,
    RM_TO_INFM = 2'd3
  } rnd_mode_t;

  // flag bit positions
  localparam int unsigned FLAG_OVF  = 0;
  localparam int unsigned FLAG_UNF  = 1;
  localparam int unsigned FLAG_SNAN = 2;
  localparam int unsigned FLAG_QNAN = 3;
  localparam int unsigned FLAG_ZERO = 4;
  localparam int unsigned FLAG_INE  = 5;
  localparam int unsigned FLAG_INV  = 6;
  localparam int unsigned FLAG_INF  = 7;

  // largest finite biased exponent
  localparam exp10_t EXP_MAX = 10'd254;

  // magnitudes without sign
  localparam logic [30:0] INF_S  = 31'h7f80_0000;
  localparam logic [30:0] QNAN_S = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_S = 31'h7fbf_ffff;

endpackage
